//--- rtl/rv_cfg_pkg.sv
package rv_cfg_pkg;

  // Width of addresses and instruction words
  localparam int XLEN = 32;

  // First fetch address after reset
  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_1000;

  // BTB geometry, direct mapped on word address bits
  localparam int BTB_IDX_BITS = 4;
  localparam int BTB_ENTRIES  = 1 << BTB_IDX_BITS;

  // Tag covers what is left above the index and the byte offset
  localparam int BTB_TAG_BITS = XLEN - BTB_IDX_BITS - 2;

endpackage

//--- rtl/rv_fetch_pkg.sv
package rv_fetch_pkg;

  // Next-pc source, in rising priority
  typedef enum logic [1:0] {
    PC_SEL_SEQUENTIAL = 2'd0,
    PC_SEL_PREDICTED  = 2'd1,
    PC_SEL_REDIRECT   = 2'd2
  } pc_sel_e;

  // Bus state of the fetch stage
  typedef enum logic [1:0] {
    WB_IDLE = 2'd0,
    WB_BUS  = 2'd1,
    WB_HOLD = 2'd2
  } wb_state_e;

  // BTB answer for the current pc
  typedef struct packed {
    logic                        hit;
    logic                        taken;
    logic [rv_cfg_pkg::XLEN-1:0] target;
  } btb_pred_t;

  // Training port from branch resolution
  typedef struct packed {
    logic                        valid;
    logic                        taken;
    logic [rv_cfg_pkg::XLEN-1:0] pc;
    logic [rv_cfg_pkg::XLEN-1:0] target;
  } btb_update_t;

  // External pc redirect
  typedef struct packed {
    logic                        valid;
    logic [rv_cfg_pkg::XLEN-1:0] target;
  } redirect_t;

  // PC stage to fetch stage
  typedef struct packed {
    logic [rv_cfg_pkg::XLEN-1:0] pc;
    logic                        pred_taken;
    logic [rv_cfg_pkg::XLEN-1:0] pred_target;
  } pc_item_t;

  // Fetch stage to decode
  typedef struct packed {
    logic [rv_cfg_pkg::XLEN-1:0] pc;
    logic [rv_cfg_pkg::XLEN-1:0] instr;
    logic                        pred_taken;
    logic [rv_cfg_pkg::XLEN-1:0] pred_target;
  } fetch_item_t;

  // Wishbone classic master outputs
  typedef struct packed {
    logic                          cyc;
    logic                          stb;
    logic [rv_cfg_pkg::XLEN-1:0]   adr;
    logic [rv_cfg_pkg::XLEN/8-1:0] sel;
  } wb_req_t;

  // Wishbone classic slave response
  typedef struct packed {
    logic                        ack;
    logic [rv_cfg_pkg::XLEN-1:0] dat;
  } wb_rsp_t;

endpackage

//--- rtl/rv_btb.sv
`timescale 1ns/1ps

module rv_btb (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [rv_cfg_pkg::XLEN-1:0] pc_i,
  output rv_fetch_pkg::btb_pred_t     pred_o,
  input  rv_fetch_pkg::btb_update_t   update_i
);

  // Entry state, only the valid bits are control
  logic [rv_cfg_pkg::BTB_ENTRIES-1:0]  valid_q;
  logic [rv_cfg_pkg::BTB_TAG_BITS-1:0] tag_q    [rv_cfg_pkg::BTB_ENTRIES];
  logic [rv_cfg_pkg::XLEN-1:0]         target_q [rv_cfg_pkg::BTB_ENTRIES];

  // Lookup side
  logic [rv_cfg_pkg::BTB_IDX_BITS-1:0] rd_idx;
  logic [rv_cfg_pkg::BTB_TAG_BITS-1:0] rd_tag;
  logic                                rd_hit;

  // Update side
  logic [rv_cfg_pkg::BTB_IDX_BITS-1:0] wr_idx;
  logic [rv_cfg_pkg::BTB_TAG_BITS-1:0] wr_tag;
  logic                                wr_tag_match;

  // Word address bits pick the entry, the rest is tag
  assign rd_idx = pc_i[rv_cfg_pkg::BTB_IDX_BITS+1:2];
  assign rd_tag = pc_i[rv_cfg_pkg::XLEN-1:rv_cfg_pkg::BTB_IDX_BITS+2];

  assign wr_idx = update_i.pc[rv_cfg_pkg::BTB_IDX_BITS+1:2];
  assign wr_tag = update_i.pc[rv_cfg_pkg::XLEN-1:rv_cfg_pkg::BTB_IDX_BITS+2];

  assign rd_hit       = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
  assign wr_tag_match = (tag_q[wr_idx] == wr_tag);

  // Combinational lookup
  // Only taken branches are ever stored, so a hit is a taken prediction
  always_comb begin
    pred_o.hit    = rd_hit;
    pred_o.taken  = rd_hit;
    pred_o.target = target_q[rd_idx];
  end

  // Valid bits
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (update_i.valid) begin
      if (update_i.taken) begin
        valid_q[wr_idx] <= 1'b1;
      end else if (wr_tag_match) begin
        // Not taken on the stored branch drops the entry
        valid_q[wr_idx] <= 1'b0;
      end
      // not taken on a different tag leaves the entry alone
    end
  end

  // Tag and target written only on taken updates
  always_ff @(posedge clk) begin
    if (update_i.valid && update_i.taken) begin
      tag_q[wr_idx]    <= wr_tag;
      target_q[wr_idx] <= update_i.target;
    end
  end

endmodule

//--- rtl/rv_pc_sel.sv
`timescale 1ns/1ps

module rv_pc_sel (
  input  rv_fetch_pkg::redirect_t     redirect_i,
  input  rv_fetch_pkg::btb_pred_t     btb_pred_i,
  output rv_fetch_pkg::pc_sel_e       pc_sel_o,
  output logic [rv_cfg_pkg::XLEN-1:0] target_o
);

  // BTB wants to steer this cycle
  logic pred_taken;

  assign pred_taken = btb_pred_i.hit && btb_pred_i.taken;

  // Fixed priority
  // Redirect first, then a taken BTB hit, then fall through to pc+4
  always_comb begin
    if (redirect_i.valid) begin
      pc_sel_o = rv_fetch_pkg::PC_SEL_REDIRECT;
      target_o = redirect_i.target;
    end else if (pred_taken) begin
      pc_sel_o = rv_fetch_pkg::PC_SEL_PREDICTED;
      target_o = btb_pred_i.target;
    end else begin
      // PC stage adds 4 itself here and ignores the target
      pc_sel_o = rv_fetch_pkg::PC_SEL_SEQUENTIAL;
      target_o = btb_pred_i.target;
    end
  end

endmodule

//--- rtl/rv_stage_pc.sv
`timescale 1ns/1ps

module rv_stage_pc (
  input  logic                        clk,
  input  logic                        rst_n,
  input  rv_fetch_pkg::pc_sel_e       pc_sel_i,
  input  logic [rv_cfg_pkg::XLEN-1:0] target_i,
  input  rv_fetch_pkg::btb_pred_t     btb_pred_i,
  output logic [rv_cfg_pkg::XLEN-1:0] pc_o,
  output rv_fetch_pkg::pc_item_t      item_o,
  output logic                        valid_o,
  input  logic                        ready_i,
  output logic                        flush_o
);

  // Next pc from the arbiter's choice
  logic [rv_cfg_pkg::XLEN-1:0] pc_next;

  // Output register free this cycle
  logic load;

  // Redirect kills whatever is in flight downstream
  assign flush_o = (pc_sel_i == rv_fetch_pkg::PC_SEL_REDIRECT);

  // Empty or being taken by the fetch stage
  assign load = !valid_o || ready_i;

  // Next-pc mux
  always_comb begin
    case (pc_sel_i)
      rv_fetch_pkg::PC_SEL_REDIRECT:  pc_next = target_i;
      rv_fetch_pkg::PC_SEL_PREDICTED: pc_next = target_i;
      default:                        pc_next = pc_o + 'd4;
    endcase
  end

  // PC register
  // Redirect loads at once, otherwise advance together with the output register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_o <= rv_cfg_pkg::RESET_PC;
    end else if (flush_o || load) begin
      pc_o <= pc_next;
    end
  end

  // Output valid
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_o <= 1'b0;
    end else if (flush_o) begin
      // Target item shows up one edge later
      valid_o <= 1'b0;
    end else if (load) begin
      valid_o <= 1'b1;
    end
  end

  // Output payload
  // Prediction comes from the lookup on the same pc, so it stays aligned
  always_ff @(posedge clk) begin
    if (load && !flush_o) begin
      item_o.pc          <= pc_o;
      item_o.pred_taken  <= btb_pred_i.hit && btb_pred_i.taken;
      item_o.pred_target <= btb_pred_i.target;
    end
  end

  // Stalled item holds until taken unless a redirect drops it
  a_item_stable : assert property (
    @(posedge clk) disable iff (!rst_n)
    valid_o && !ready_i && !flush_o |=> valid_o && $stable(item_o)
  );

  // Nothing from the old path is offered after a flush
  a_flush_clears : assert property (
    @(posedge clk) disable iff (!rst_n)
    flush_o |=> !valid_o
  );

endmodule

//--- rtl/rv_stage_if_wb.sv
`timescale 1ns/1ps

module rv_stage_if_wb (
  input  logic                      clk,
  input  logic                      rst_n,
  input  rv_fetch_pkg::pc_item_t    item_i,
  input  logic                      valid_i,
  output logic                      ready_o,
  input  logic                      flush_i,
  output rv_fetch_pkg::wb_req_t     wb_o,
  input  rv_fetch_pkg::wb_rsp_t     wb_i,
  output rv_fetch_pkg::fetch_item_t fetch_o,
  output logic                      fetch_valid_o,
  input  logic                      fetch_ready_i
);

  rv_fetch_pkg::wb_state_e   state_q;
  rv_fetch_pkg::fetch_item_t req_q;
  rv_fetch_pkg::fetch_item_t out_d;
  logic                      discard_q;
  logic                      accept;
  logic                      out_free;
  logic                      out_load;

  // One item at a time, never take an old-path item during a flush
  assign ready_o  = (state_q == rv_fetch_pkg::WB_IDLE) && !flush_i;
  assign accept   = valid_i && ready_o;
  assign out_free = !fetch_valid_o || fetch_ready_i;

  // Fill the decode register from ack data or from the held word
  assign out_load = !flush_i && out_free &&
                    ((state_q == rv_fetch_pkg::WB_BUS && wb_i.ack && !discard_q) ||
                     (state_q == rv_fetch_pkg::WB_HOLD));

  always_comb begin
    out_d = req_q;
    if (state_q == rv_fetch_pkg::WB_BUS) begin
      out_d.instr = wb_i.dat;
    end
  end

  // Classic read, cyc and stb together for the whole bus state
  always_comb begin
    wb_o.cyc = (state_q == rv_fetch_pkg::WB_BUS);
    wb_o.stb = (state_q == rv_fetch_pkg::WB_BUS);
    wb_o.adr = req_q.pc;
    wb_o.sel = '1;
  end

  // Bus FSM
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q   <= rv_fetch_pkg::WB_IDLE;
      discard_q <= 1'b0;
    end else begin
      case (state_q)
        rv_fetch_pkg::WB_IDLE: begin
          if (accept) begin
            state_q   <= rv_fetch_pkg::WB_BUS;
            discard_q <= 1'b0;
          end
        end
        rv_fetch_pkg::WB_BUS: begin
          if (wb_i.ack) begin
            // Park the word if decode is still stalled
            if (discard_q || flush_i || out_free) begin
              state_q <= rv_fetch_pkg::WB_IDLE;
            end else begin
              state_q <= rv_fetch_pkg::WB_HOLD;
            end
          end else if (flush_i) begin
            // No abort on classic, finish the cycle and drop the data
            discard_q <= 1'b1;
          end
        end
        rv_fetch_pkg::WB_HOLD: begin
          if (flush_i || out_free) begin
            state_q <= rv_fetch_pkg::WB_IDLE;
          end
        end
        default: state_q <= rv_fetch_pkg::WB_IDLE;
      endcase
    end
  end

  // Request payload, instr slot reused as the hold buffer
  always_ff @(posedge clk) begin
    if (accept) begin
      req_q.pc          <= item_i.pc;
      req_q.pred_taken  <= item_i.pred_taken;
      req_q.pred_target <= item_i.pred_target;
    end
    if (state_q == rv_fetch_pkg::WB_BUS && wb_i.ack) begin
      req_q.instr <= wb_i.dat;
    end
  end

  // Decode-side output register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fetch_valid_o <= 1'b0;
    end else if (flush_i) begin
      fetch_valid_o <= 1'b0;
    end else if (out_load) begin
      fetch_valid_o <= 1'b1;
    end else if (fetch_ready_i) begin
      fetch_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (out_load) begin
      fetch_o <= out_d;
    end
  end

  // Strobe only inside a cycle
  a_stb_in_cyc : assert property (
    @(posedge clk) disable iff (!rst_n)
    wb_o.stb |-> wb_o.cyc
  );

  // Address held until the slave answers
  a_adr_hold : assert property (
    @(posedge clk) disable iff (!rst_n)
    wb_o.stb && !wb_i.ack |=> wb_o.stb && $stable(wb_o.adr)
  );

endmodule

//--- rtl/rv_frontend_top.sv
`timescale 1ns/1ps

module rv_frontend_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  rv_fetch_pkg::redirect_t   redirect_i,
  input  rv_fetch_pkg::btb_update_t btb_update_i,
  output rv_fetch_pkg::wb_req_t     wb_o,
  input  rv_fetch_pkg::wb_rsp_t     wb_i,
  output rv_fetch_pkg::fetch_item_t fetch_o,
  output logic                      fetch_valid_o,
  input  logic                      fetch_ready_i
);

  // PC register, shared by BTB lookup and the PC stage
  logic [rv_cfg_pkg::XLEN-1:0] pc_cur;

  // Arbitration results
  rv_fetch_pkg::btb_pred_t     btb_pred;
  rv_fetch_pkg::pc_sel_e       pc_sel;
  logic [rv_cfg_pkg::XLEN-1:0] sel_target;

  // PC stage to fetch stage link
  rv_fetch_pkg::pc_item_t      pc_item;
  logic                        pc_valid;
  logic                        pc_ready;
  logic                        flush;

  rv_btb u_btb (
    .clk      (clk),
    .rst_n    (rst_n),
    .pc_i     (pc_cur),
    .pred_o   (btb_pred),
    .update_i (btb_update_i)
  );

  rv_pc_sel u_pc_sel (
    .redirect_i (redirect_i),
    .btb_pred_i (btb_pred),
    .pc_sel_o   (pc_sel),
    .target_o   (sel_target)
  );

  rv_stage_pc u_stage_pc (
    .clk        (clk),
    .rst_n      (rst_n),
    .pc_sel_i   (pc_sel),
    .target_i   (sel_target),
    .btb_pred_i (btb_pred),
    .pc_o       (pc_cur),
    .item_o     (pc_item),
    .valid_o    (pc_valid),
    .ready_i    (pc_ready),
    .flush_o    (flush)
  );

  rv_stage_if_wb u_stage_if (
    .clk           (clk),
    .rst_n         (rst_n),
    .item_i        (pc_item),
    .valid_i       (pc_valid),
    .ready_o       (pc_ready),
    .flush_i       (flush),
    .wb_o          (wb_o),
    .wb_i          (wb_i),
    .fetch_o       (fetch_o),
    .fetch_valid_o (fetch_valid_o),
    .fetch_ready_i (fetch_ready_i)
  );

endmodule

//--- verif/rv_frontend_tb.sv
`timescale 1ns/1ps

module rv_frontend_tb;

  // Memory returns the address with this pattern folded in
  localparam logic [rv_cfg_pkg::XLEN-1:0] INSTR_KEY = 32'h5a5a_0000;
  localparam int TIMEOUT = 200;

  logic                      clk = 1'b0;
  logic                      rst_n;
  rv_fetch_pkg::redirect_t   redirect_i;
  rv_fetch_pkg::btb_update_t btb_update_i;
  rv_fetch_pkg::wb_req_t     wb_o;
  rv_fetch_pkg::wb_rsp_t     wb_i;
  rv_fetch_pkg::fetch_item_t fetch_o;
  logic                      fetch_valid_o;
  logic                      fetch_ready_i;

  // Random pool, filled once from the seeded generator
  logic [31:0] rnd [256];
  logic [7:0]  slv_ptr = 8'd0;
  logic [7:0]  rdy_ptr = 8'd0;
  int          wait_left = 0;

  // Delivered items and acked bus addresses
  rv_fetch_pkg::fetch_item_t   got_q [$];
  logic [rv_cfg_pkg::XLEN-1:0] bus_q [$];
  int rd_ptr = 0;
  int redirect_cnt = 0;
  int seen_redir = 0;
  int skip_left = 0;
  int errors = 0;
  int checks = 0;
  int addr_checks = 0;

  logic ready_random = 1'b0;
  logic done = 1'b0;
  logic abort = 1'b0;
  logic stalled_q = 1'b0;
  rv_fetch_pkg::fetch_item_t held_item;

  rv_frontend_top dut_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect_i),
    .btb_update_i  (btb_update_i),
    .wb_o          (wb_o),
    .wb_i          (wb_i),
    .fetch_o       (fetch_o),
    .fetch_valid_o (fetch_valid_o),
    .fetch_ready_i (fetch_ready_i)
  );

  always #4 clk = ~clk;

  // Item the memory rule gives for a pc, no prediction
  function automatic rv_fetch_pkg::fetch_item_t expect_item(
    input logic [rv_cfg_pkg::XLEN-1:0] pc
  );
    rv_fetch_pkg::fetch_item_t it;
    it       = '0;
    it.pc    = pc;
    it.instr = pc ^ INSTR_KEY;
    return it;
  endfunction

  task automatic check_item(input string name, input rv_fetch_pkg::fetch_item_t exp,
                            input rv_fetch_pkg::fetch_item_t act);
    checks++;
    if (act.pc !== exp.pc || act.instr !== exp.instr) begin
      errors++;
      $display("FAIL %s: expected pc %h instr %h, got pc %h instr %h",
               name, exp.pc, exp.instr, act.pc, act.instr);
    end
  endtask

  // Target only matters when a prediction is expected
  task automatic check_pred(input string name, input logic exp_taken,
                            input logic [rv_cfg_pkg::XLEN-1:0] exp_target,
                            input rv_fetch_pkg::fetch_item_t act);
    checks++;
    if (act.pred_taken !== exp_taken || (exp_taken && act.pred_target !== exp_target)) begin
      errors++;
      $display("FAIL %s: expected taken %b target %h, got taken %b target %h",
               name, exp_taken, exp_target, act.pred_taken, act.pred_target);
    end
  endtask

  task automatic check_addr(input string name, input logic [rv_cfg_pkg::XLEN-1:0] exp,
                            input logic [rv_cfg_pkg::XLEN-1:0] act);
    addr_checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %s: expected adr %h, got adr %h", name, exp, act);
    end
  endtask

  // Word fetches enable every byte lane
  task automatic check_sel(input string name, input logic [rv_cfg_pkg::XLEN/8-1:0] exp,
                           input logic [rv_cfg_pkg::XLEN/8-1:0] act);
    if (act !== exp) begin
      errors++;
      $display("FAIL %s: expected sel %h, got sel %h", name, exp, act);
    end
  endtask

  // Pair a delivered pc with its bus read
  // Reads dropped by a flush sit in front of the first new-path read
  task automatic match_bus(input logic [rv_cfg_pkg::XLEN-1:0] pc);
    while (bus_q.size() > 0 && bus_q[0] != pc && skip_left > 0) begin
      void'(bus_q.pop_front());
      skip_left--;
    end
    if (bus_q.size() == 0) begin
      errors++;
      $display("ERROR: item at pc %h delivered without a Wishbone read", pc);
    end else begin
      check_addr("bus_addr", pc, bus_q.pop_front());
      skip_left = 0;
    end
  endtask

  // Main thread lives 1 ns after the rising edge
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic next_item(input string name, output rv_fetch_pkg::fetch_item_t it);
    int cycles;
    cycles = 0;
    while (got_q.size() <= rd_ptr && cycles < TIMEOUT) begin
      step();
      cycles++;
    end
    if (got_q.size() <= rd_ptr) begin
      errors++;
      $display("ERROR %s: no item delivered within %0d cycles", name, TIMEOUT);
      abort = 1'b1;
      @(negedge clk);
    end
    it = got_q[rd_ptr];
    rd_ptr++;
  endtask

  // Gap-free run from start, no prediction flags
  task automatic expect_run(input string name, input logic [rv_cfg_pkg::XLEN-1:0] start,
                            input int count);
    rv_fetch_pkg::fetch_item_t   it;
    logic [rv_cfg_pkg::XLEN-1:0] pc;
    pc = start;
    for (int k = 0; k < count; k++) begin
      next_item(name, it);
      check_item(name, expect_item(pc), it);
      check_pred(name, 1'b0, '0, it);
      pc = pc + 32'd4;
    end
  endtask

  // One-cycle redirect pulse, items seen up to its edge are old path
  task automatic drive_redirect(input logic [rv_cfg_pkg::XLEN-1:0] target);
    redirect_i.valid  = 1'b1;
    redirect_i.target = target;
    redirect_cnt++;
    step();
    redirect_i = '0;
    rd_ptr = got_q.size();
  endtask

  task automatic drive_btb_update(input logic taken, input logic [rv_cfg_pkg::XLEN-1:0] pc,
                                  input logic [rv_cfg_pkg::XLEN-1:0] target);
    btb_update_i.valid  = 1'b1;
    btb_update_i.taken  = taken;
    btb_update_i.pc     = pc;
    btb_update_i.target = target;
    step();
    btb_update_i = '0;
  endtask

  task automatic sequential_fetch();
    step();
    if (fetch_valid_o !== 1'b0 || wb_o.cyc !== 1'b0) begin
      errors++;
      $display("ERROR: fetch_valid_o or wb_o.cyc high right after reset");
    end
    expect_run("sequential", rv_cfg_pkg::RESET_PC, 10);
  endtask

  task automatic backpressure_run();
    drive_redirect(32'h0000_4000);
    ready_random = 1'b1;
    expect_run("backpressure", 32'h0000_4000, 20);
  endtask

  // Ready stays random so the flush can land on a stalled item
  task automatic redirect_mid_stream();
    logic [rv_cfg_pkg::XLEN-1:0] target;
    target = 32'h0000_6000 + ($urandom_range(63, 0) << 2);
    repeat ($urandom_range(20, 3)) step();
    drive_redirect(target);
    expect_run("redirect", target, 12);
    ready_random = 1'b0;
  endtask

  task automatic btb_training();
    rv_fetch_pkg::fetch_item_t it;
    drive_btb_update(1'b1, 32'h0000_2040, 32'h0000_3000);
    drive_redirect(32'h0000_2038);
    expect_run("btb_train", 32'h0000_2038, 2);
    next_item("btb_train", it);
    check_item("btb_train", expect_item(32'h0000_2040), it);
    check_pred("btb_train", 1'b1, 32'h0000_3000, it);
    expect_run("btb_train", 32'h0000_3000, 2);
  endtask

  task automatic btb_untraining();
    drive_btb_update(1'b0, 32'h0000_2040, 32'h0000_0000);
    drive_redirect(32'h0000_2038);
    expect_run("btb_untrain", 32'h0000_2038, 4);
    if (addr_checks == 0) begin
      errors++;
      $display("ERROR: no Wishbone read address was ever checked");
    end
  endtask

  // Wishbone slave, ack after 0 to 3 wait cycles
  initial begin
    wb_i = '0;
    forever begin
      step();
      if (rst_n && wb_o.cyc && wb_o.stb) begin
        if (wait_left == 0) begin
          wb_i.ack = 1'b1;
          wb_i.dat = wb_o.adr ^ INSTR_KEY;
        end else begin
          wait_left = wait_left - 1;
        end
      end else begin
        wb_i.ack  = 1'b0;
        wait_left = rnd[slv_ptr] % 4;
        slv_ptr++;
      end
    end
  end

  // Decode-side ready
  initial begin
    fetch_ready_i = 1'b0;
    forever begin
      step();
      if (ready_random) begin
        fetch_ready_i = rnd[rdy_ptr][0];
        rdy_ptr++;
      end else begin
        fetch_ready_i = 1'b1;
      end
    end
  end

  // Monitor on pre-edge values
  always @(posedge clk) begin
    if (rst_n) begin
      if (wb_o.stb && !wb_o.cyc) begin
        errors++;
        $display("ERROR: wb_o.stb high without wb_o.cyc at %0t", $time);
      end
      if (wb_o.cyc && wb_o.stb) begin
        check_sel("bus_sel", '1, wb_o.sel);
      end
      if (wb_o.cyc && wb_o.stb && wb_i.ack) begin
        bus_q.push_back(wb_o.adr);
      end
      if (stalled_q && fetch_valid_o) begin
        check_item("stall_hold", held_item, fetch_o);
      end
      // An item taken on the flush edge is still old path and pairs in order
      if (fetch_valid_o && fetch_ready_i) begin
        got_q.push_back(fetch_o);
        match_bus(fetch_o.pc);
      end
      // Up to two reads can be left over once a flush hits
      if (redirect_cnt != seen_redir) begin
        skip_left  = 2;
        seen_redir = redirect_cnt;
      end
      stalled_q = fetch_valid_o && !fetch_ready_i;
      held_item = fetch_o;
    end
  end

  initial begin
    rst_n        = 1'b0;
    redirect_i   = '0;
    btb_update_i = '0;
    void'($urandom(32'hb1d0_fc11));
    foreach (rnd[i]) begin
      rnd[i] = $urandom;
    end
    repeat (8) step();
    rst_n = 1'b1;
    sequential_fetch();
    backpressure_run();
    redirect_mid_stream();
    btb_training();
    btb_untraining();
    done = 1'b1;
  end

  // End of run, normal or after a timeout
  initial begin
    wait (done || abort);
    $display("Errors: %0d, item checks: %0d, bus address checks: %0d",
             errors, checks, addr_checks);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- rv_frontend_top.f
rtl/rv_cfg_pkg.sv
rtl/rv_fetch_pkg.sv
rtl/rv_btb.sv
rtl/rv_pc_sel.sv
rtl/rv_stage_pc.sv
rtl/rv_stage_if_wb.sv
rtl/rv_frontend_top.sv
verif/rv_frontend_tb.sv

//--- Makefile
SIM := obj_dir/Vrv_frontend_tb

.PHONY: all run clean

all: run

# Rebuild only when the file list or a source file changes
$(SIM): rv_frontend_top.f $(wildcard rtl/*.sv) $(wildcard verif/*.sv)
	verilator --binary --timing --assert -j 0 --top-module rv_frontend_tb -f rv_frontend_top.f

# A simulator crash or a failed assertion also counts as a failing run
run: $(SIM)
	$(SIM) > sim.log 2>&1 || echo "SIMULATION FAILED" >> sim.log
	@cat sim.log
	@! grep -q "SIMULATION FAILED" sim.log

clean:
	rm -rf obj_dir sim.log
